/* common/mcpu_settings.svh */
// Core-wide widths and depths for the mcpu pipeline
// Shared by the package and by the datapath stages
`ifndef MCPU_SETTINGS_SVH
`define MCPU_SETTINGS_SVH

// Data word and instruction widths
`define MCPU_XLEN 16
`define MCPU_ILEN 16
// Register file entries, r0 reads as zero
`define MCPU_NREGS 8
// Internal data memory depth in words
`define MCPU_DMEM_DEPTH 16
// Program counter width, counted in instruction words
`define MCPU_PC_W 8
// Immediate and branch offset field
`define MCPU_IMM_W 6

`endif

/* common/mcpu_pkg.sv */
// Shared types of the mcpu core
// Word, register index, PC and instruction vectors, plus the
// opcode, forwarding select and controller state encodings
`default_nettype none

`include "mcpu_settings.svh"

package mcpu_pkg;

  // Plain vectors with a meaning
  typedef logic [`MCPU_XLEN-1:0]          word_t;
  typedef logic [$clog2(`MCPU_NREGS)-1:0] rf_addr_t;
  typedef logic [`MCPU_PC_W-1:0]          pc_t;
  typedef logic [`MCPU_ILEN-1:0]          instr_t;

  // Opcode field, instruction bits 15..12
  // Unlisted codes decode like NOP
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    ADDI = 4'h4,
    LD   = 4'h5,
    ST   = 4'h6,
    BEQ  = 4'h7,
    HALT = 4'h8,
    NOP  = 4'hF
  } opcode_e;

  // Operand source in ID
  typedef enum logic [1:0] {
    REGFILE = 2'b00,
    FW_EX   = 2'b01,
    FW_WB   = 2'b10
  } op_fw_mux_e;

  // Main controller states
  typedef enum logic [2:0] {
    RESET,
    BOOT,
    RUN,
    DRAIN,
    HALTED
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/controller/mcpu_controller_fsm.sv */
// Main control FSM of the mcpu core
// Boot and fetch enable, branch redirect, load stall hold,
// HALT drain, per-stage halt and kill strobes, busy flag
`timescale 1ns/1ns
`default_nettype none

module mcpu_controller_fsm import mcpu_pkg::*; (
  input  logic clk,
  input  logic rst_i,
  input  logic fetch_enable_i,
  input  logic branch_taken_i,
  input  logic halt_ex_i,
  input  logic load_stall_i,
  output logic pc_set_o,
  output logic halt_if_o,
  output logic halt_id_o,
  output logic kill_id_o,
  output logic kill_ex_o,
  output logic ctrl_busy_o,
  output logic halted_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d   = state_q;
    pc_set_o  = 1'b0;
    halt_if_o = 1'b0;
    halt_id_o = 1'b0;
    kill_id_o = 1'b0;
    kill_ex_o = 1'b0;

    case (state_q)
      // One cycle after reset release
      RESET: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_d   = BOOT;
      end
      // PC parked at 0 until enabled
      BOOT: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (halt_ex_i) begin
          // Squash everything younger than HALT
          halt_if_o = 1'b1;
          kill_id_o = 1'b1;
          kill_ex_o = 1'b1;
          state_d   = DRAIN;
        end else if (branch_taken_i) begin
          // Redirect, drop the two wrong-path instructions
          pc_set_o  = 1'b1;
          kill_id_o = 1'b1;
          kill_ex_o = 1'b1;
        end else if (load_stall_i) begin
          // Hold IF and ID, bubble into EX
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          kill_ex_o = 1'b1;
        end
      end
      // HALT sits in WB, nothing left to retire
      DRAIN: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_d   = HALTED;
      end
      // Stays here until reset
      HALTED: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
      end
      default: begin
        state_d = RESET;
      end
    endcase
  end

  // Status
  assign ctrl_busy_o = (state_q == RUN) || (state_q == DRAIN);
  assign halted_o    = (state_q == HALTED);

endmodule

`default_nettype wire

/* hw/controller/mcpu_controller_bypass.sv */
// Hazard and bypass unit of the mcpu core
// Operand forwarding selects for ID, load-use stall detection
// and the write enable deassert for the stalled copy
`timescale 1ns/1ns
`default_nettype none

module mcpu_controller_bypass import mcpu_pkg::*; (
  input  rf_addr_t   rs1_id_i,
  input  rf_addr_t   rs2_id_i,
  input  logic       rs1_re_i,
  input  logic       rs2_re_i,
  input  rf_addr_t   rd_ex_i,
  input  logic       we_ex_i,
  input  logic       load_ex_i,
  input  rf_addr_t   rd_wb_i,
  input  logic       we_wb_i,
  input  logic       if_valid_i,
  output op_fw_mux_e fw_a_sel_o,
  output op_fw_mux_e fw_b_sel_o,
  output logic       load_stall_o,
  output logic       deassert_we_o
);

  // EX and WB write a real register
  logic ex_writes;
  logic wb_writes;
  // Address matches per source
  logic rs1_hit_ex;
  logic rs2_hit_ex;
  logic rs1_hit_wb;
  logic rs2_hit_wb;

  assign ex_writes = we_ex_i && (rd_ex_i != '0);
  assign wb_writes = we_wb_i && (rd_wb_i != '0);

  assign rs1_hit_ex = ex_writes && (rd_ex_i == rs1_id_i);
  assign rs2_hit_ex = ex_writes && (rd_ex_i == rs2_id_i);
  assign rs1_hit_wb = wb_writes && (rd_wb_i == rs1_id_i);
  assign rs2_hit_wb = wb_writes && (rd_wb_i == rs2_id_i);

  ////////////////////////////////////////////////////////////
  // Forwarding selects, youngest producer first
  ////////////////////////////////////////////////////////////
  // Load data is not ready in EX, that case stalls instead
  assign fw_a_sel_o = (rs1_hit_ex && !load_ex_i) ? FW_EX :
                      rs1_hit_wb                 ? FW_WB : REGFILE;
  assign fw_b_sel_o = (rs2_hit_ex && !load_ex_i) ? FW_EX :
                      rs2_hit_wb                 ? FW_WB : REGFILE;

  // Load-use hazard on a source that is actually read
  assign load_stall_o = if_valid_i && load_ex_i &&
                        ((rs1_re_i && rs1_hit_ex) || (rs2_re_i && rs2_hit_ex));

  // Stalled copy in ID must not write
  assign deassert_we_o = load_stall_o;

endmodule

`default_nettype wire

/* hw/controller/mcpu_controller.sv */
// Pipeline controller of the mcpu core
// Main FSM plus the hazard and bypass unit, the load stall
// of the bypass unit feeds the FSM halt and kill logic
`timescale 1ns/1ns
`default_nettype none

module mcpu_controller import mcpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,

  input  logic       fetch_enable_i,   // Start fetching after boot
  input  logic       branch_taken_i,   // Taken BEQ in EX
  input  logic       halt_ex_i,        // HALT in EX

  // Sources of the instruction in ID
  input  rf_addr_t   rs1_id_i,
  input  rf_addr_t   rs2_id_i,
  input  logic       rs1_re_i,
  input  logic       rs2_re_i,
  input  logic       if_valid_i,

  // Destinations in EX and WB
  input  rf_addr_t   rd_ex_i,
  input  logic       we_ex_i,
  input  logic       load_ex_i,
  input  rf_addr_t   rd_wb_i,
  input  logic       we_wb_i,

  output logic       pc_set_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       kill_id_o,
  output logic       kill_ex_o,
  output op_fw_mux_e fw_a_sel_o,
  output op_fw_mux_e fw_b_sel_o,
  output logic       deassert_we_o,
  output logic       ctrl_busy_o,
  output logic       halted_o
);

  // Link from hazard unit to FSM
  logic load_stall;

  mcpu_controller_fsm i_controller_fsm (
    .clk            ( clk            ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .branch_taken_i ( branch_taken_i ),
    .halt_ex_i      ( halt_ex_i      ),
    .load_stall_i   ( load_stall     ),
    .pc_set_o       ( pc_set_o       ),
    .halt_if_o      ( halt_if_o      ),
    .halt_id_o      ( halt_id_o      ),
    .kill_id_o      ( kill_id_o      ),
    .kill_ex_o      ( kill_ex_o      ),
    .ctrl_busy_o    ( ctrl_busy_o    ),
    .halted_o       ( halted_o       )
  );

  mcpu_controller_bypass i_controller_bypass (
    .rs1_id_i       ( rs1_id_i       ),
    .rs2_id_i       ( rs2_id_i       ),
    .rs1_re_i       ( rs1_re_i       ),
    .rs2_re_i       ( rs2_re_i       ),
    .rd_ex_i        ( rd_ex_i        ),
    .we_ex_i        ( we_ex_i        ),
    .load_ex_i      ( load_ex_i      ),
    .rd_wb_i        ( rd_wb_i        ),
    .we_wb_i        ( we_wb_i        ),
    .if_valid_i     ( if_valid_i     ),
    .fw_a_sel_o     ( fw_a_sel_o     ),
    .fw_b_sel_o     ( fw_b_sel_o     ),
    .load_stall_o   ( load_stall     ),
    .deassert_we_o  ( deassert_we_o  )
  );

endmodule

`default_nettype wire

/* hw/mcpu_if_stage.sv */
// Instruction fetch stage of the mcpu core
// PC with next-PC select and the IF/ID pipeline register
`timescale 1ns/1ns
`default_nettype none

module mcpu_if_stage import mcpu_pkg::*; (
  input  logic   clk,
  input  logic   rst_i,
  input  logic   halt_if_i,
  input  logic   kill_id_i,
  input  logic   pc_set_i,
  input  pc_t    branch_target_i,
  input  instr_t instr_rdata_i,
  output pc_t    instr_addr_o,
  output instr_t if_instr_o,
  output pc_t    if_pc_o,
  output logic   if_valid_o
);

  pc_t pc_q;

  // Combinational instruction port
  assign instr_addr_o = pc_q;

  // Next PC: redirect, hold or increment
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= '0;
    end else if (pc_set_i) begin
      pc_q <= branch_target_i;
    end else if (!halt_if_i) begin
      pc_q <= pc_q + pc_t'(1);
    end
  end

  // IF/ID valid, kill wins over hold
  always_ff @(posedge clk) begin
    if (rst_i) begin
      if_valid_o <= 1'b0;
    end else if (kill_id_i) begin
      if_valid_o <= 1'b0;
    end else if (!halt_if_i) begin
      if_valid_o <= 1'b1;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (!halt_if_i) begin
      if_instr_o <= instr_rdata_i;
      if_pc_o    <= pc_q;
    end
  end

endmodule

`default_nettype wire

/* hw/mcpu_id_stage.sv */
// Instruction decode stage of the mcpu core
// Decoder, register file with the writeback port, operand
// forwarding muxes and the ID/EX pipeline register
`timescale 1ns/1ns
`default_nettype none

`include "mcpu_settings.svh"

module mcpu_id_stage import mcpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  instr_t     if_instr_i,
  input  pc_t        if_pc_i,
  input  logic       if_valid_i,
  input  logic       halt_id_i,
  input  logic       kill_ex_i,
  input  logic       deassert_we_i,
  input  op_fw_mux_e fw_a_sel_i,
  input  op_fw_mux_e fw_b_sel_i,
  input  word_t      ex_result_i,
  input  logic       wb_we_i,
  input  rf_addr_t   wb_waddr_i,
  input  word_t      wb_wdata_i,
  // To the hazard unit
  output rf_addr_t   rs1_o,
  output rf_addr_t   rs2_o,
  output logic       rs1_re_o,
  output logic       rs2_re_o,
  // ID/EX register
  output opcode_e    ex_op_o,
  output word_t      ex_opa_o,
  output word_t      ex_opb_o,
  output word_t      ex_imm_o,
  output rf_addr_t   ex_rd_o,
  output logic       ex_we_o,
  output pc_t        ex_pc_o,
  output logic       ex_valid_o
);

  opcode_e  dec_op;
  rf_addr_t dec_rd;
  word_t    dec_imm;
  logic     dec_we;
  logic     issue;
  word_t    rf_q [`MCPU_NREGS];
  word_t    rs1_rdata;
  word_t    rs2_rdata;

  // Operand source select
  function automatic word_t fw_mux(op_fw_mux_e sel, word_t rf, word_t ex, word_t wb);
    case (sel)
      FW_EX:   return ex;
      FW_WB:   return wb;
      default: return rf;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////
  assign dec_op  = opcode_e'(if_instr_i[15:12]);
  assign dec_rd  = if_instr_i[11:9];
  assign rs1_o   = if_instr_i[8:6];
  // Sign-extended 6-bit immediate or offset
  assign dec_imm = {{(`MCPU_XLEN-`MCPU_IMM_W){if_instr_i[`MCPU_IMM_W-1]}},
                    if_instr_i[`MCPU_IMM_W-1:0]};

  always_comb begin
    dec_we   = 1'b0;
    rs1_re_o = 1'b0;
    rs2_re_o = 1'b0;
    rs2_o    = if_instr_i[5:3];
    case (dec_op)
      ADD, SUB, AND, OR: begin
        dec_we   = 1'b1;
        rs1_re_o = 1'b1;
        rs2_re_o = 1'b1;
      end
      ADDI, LD: begin
        dec_we   = 1'b1;
        rs1_re_o = 1'b1;
      end
      // Second source sits in the rd field
      ST, BEQ: begin
        rs1_re_o = 1'b1;
        rs2_re_o = 1'b1;
        rs2_o    = dec_rd;
      end
      default: begin
      end
    endcase
  end

  // Register file, written from EX/WB at the edge
  always_ff @(posedge clk) begin
    if (wb_we_i && (wb_waddr_i != '0)) begin
      rf_q[wb_waddr_i] <= wb_wdata_i;
    end
  end

  // r0 reads as zero
  assign rs1_rdata = (rs1_o == '0) ? '0 : rf_q[rs1_o];
  assign rs2_rdata = (rs2_o == '0) ? '0 : rf_q[rs2_o];

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////
  // Hold or kill turns into a bubble
  assign issue = if_valid_i && !kill_ex_i && !halt_id_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_valid_o <= 1'b0;
      ex_we_o    <= 1'b0;
    end else begin
      ex_valid_o <= issue;
      ex_we_o    <= issue && dec_we && !deassert_we_i;
    end
  end

  always_ff @(posedge clk) begin
    ex_op_o  <= dec_op;
    ex_opa_o <= fw_mux(fw_a_sel_i, rs1_rdata, ex_result_i, wb_wdata_i);
    ex_opb_o <= fw_mux(fw_b_sel_i, rs2_rdata, ex_result_i, wb_wdata_i);
    ex_imm_o <= dec_imm;
    ex_rd_o  <= dec_rd;
    ex_pc_o  <= if_pc_i;
  end

endmodule

`default_nettype wire

/* hw/mcpu_ex_stage.sv */
// Execute stage of the mcpu core
// ALU, BEQ compare and target, internal data memory and
// the EX/WB register that drives the writeback port
`timescale 1ns/1ns
`default_nettype none

`include "mcpu_settings.svh"

module mcpu_ex_stage import mcpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  opcode_e  ex_op_i,
  input  word_t    ex_opa_i,
  input  word_t    ex_opb_i,
  input  word_t    ex_imm_i,
  input  rf_addr_t ex_rd_i,
  input  logic     ex_we_i,
  input  pc_t      ex_pc_i,
  input  logic     ex_valid_i,
  output word_t    ex_result_o,
  output logic     branch_taken_o,
  output pc_t      branch_target_o,
  output logic     halt_ex_o,
  output rf_addr_t rd_ex_o,
  output logic     we_ex_o,
  output logic     load_ex_o,
  output logic     wb_we_o,
  output rf_addr_t wb_waddr_o,
  output word_t    wb_wdata_o
);

  localparam int DMEM_AW = $clog2(`MCPU_DMEM_DEPTH);

  word_t              dmem_q [`MCPU_DMEM_DEPTH];
  word_t              alu_result;
  logic [DMEM_AW-1:0] dmem_addr;
  logic               is_store;

  // ALU, immediate add doubles as LD/ST address
  always_comb begin
    case (ex_op_i)
      ADD:     alu_result = ex_opa_i + ex_opb_i;
      SUB:     alu_result = ex_opa_i - ex_opb_i;
      AND:     alu_result = ex_opa_i & ex_opb_i;
      OR:      alu_result = ex_opa_i | ex_opb_i;
      default: alu_result = ex_opa_i + ex_imm_i;
    endcase
  end

  assign ex_result_o = alu_result;

  // BEQ, target relative to the branch PC plus one
  assign branch_taken_o  = ex_valid_i && (ex_op_i == BEQ) && (ex_opa_i == ex_opb_i);
  assign branch_target_o = ex_pc_i + pc_t'(1) + ex_imm_i[`MCPU_PC_W-1:0];
  assign halt_ex_o       = ex_valid_i && (ex_op_i == HALT);

  // Destination info for the hazard unit
  assign rd_ex_o   = ex_rd_i;
  assign we_ex_o   = ex_we_i;
  assign load_ex_o = ex_valid_i && (ex_op_i == LD);
  assign is_store  = ex_valid_i && (ex_op_i == ST);

  ////////////////////////////////////////////////////////////
  // Data memory, combinational read and edge write
  ////////////////////////////////////////////////////////////
  assign dmem_addr = alu_result[DMEM_AW-1:0];

  always_ff @(posedge clk) begin
    if (is_store) begin
      dmem_q[dmem_addr] <= ex_opb_i;
    end
  end

  // EX/WB register
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_we_o <= 1'b0;
    end else begin
      wb_we_o <= ex_we_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_waddr_o <= ex_rd_i;
    wb_wdata_o <= load_ex_o ? dmem_q[dmem_addr] : alu_result;
  end

endmodule

`default_nettype wire

/* hw/mcpu_top.sv */
// Top level of the mcpu four-stage pipeline
// Connects fetch, decode, execute and the pipeline controller
`timescale 1ns/1ns
`default_nettype none

module mcpu_top import mcpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     fetch_enable_i,
  output pc_t      instr_addr_o,
  input  instr_t   instr_rdata_i,
  output logic     wb_we_o,
  output rf_addr_t wb_waddr_o,
  output word_t    wb_wdata_o,
  output logic     ctrl_busy_o,
  output logic     halted_o
);

  // Controller strobes
  logic       pc_set;
  logic       halt_if;
  logic       halt_id;
  logic       kill_id;
  logic       kill_ex;
  logic       deassert_we;
  op_fw_mux_e fw_a_sel;
  op_fw_mux_e fw_b_sel;
  // IF/ID
  instr_t     if_instr;
  pc_t        if_pc;
  logic       if_valid;
  // ID to hazard unit
  rf_addr_t   rs1_id;
  rf_addr_t   rs2_id;
  logic       rs1_re;
  logic       rs2_re;
  // ID/EX
  opcode_e    ex_op;
  word_t      ex_opa;
  word_t      ex_opb;
  word_t      ex_imm;
  rf_addr_t   ex_rd;
  logic       ex_we;
  pc_t        ex_pc;
  logic       ex_valid;
  // EX results
  word_t      ex_result;
  logic       branch_taken;
  pc_t        branch_target;
  logic       halt_ex;
  rf_addr_t   rd_ex;
  logic       we_ex;
  logic       load_ex;

  mcpu_if_stage i_if_stage (
    .clk             ( clk           ),
    .rst_i           ( rst_i         ),
    .halt_if_i       ( halt_if       ),
    .kill_id_i       ( kill_id       ),
    .pc_set_i        ( pc_set        ),
    .branch_target_i ( branch_target ),
    .instr_rdata_i   ( instr_rdata_i ),
    .instr_addr_o    ( instr_addr_o  ),
    .if_instr_o      ( if_instr      ),
    .if_pc_o         ( if_pc         ),
    .if_valid_o      ( if_valid      )
  );

  mcpu_id_stage i_id_stage (
    .clk           ( clk         ),
    .rst_i         ( rst_i       ),
    .if_instr_i    ( if_instr    ),
    .if_pc_i       ( if_pc       ),
    .if_valid_i    ( if_valid    ),
    .halt_id_i     ( halt_id     ),
    .kill_ex_i     ( kill_ex     ),
    .deassert_we_i ( deassert_we ),
    .fw_a_sel_i    ( fw_a_sel    ),
    .fw_b_sel_i    ( fw_b_sel    ),
    .ex_result_i   ( ex_result   ),
    .wb_we_i       ( wb_we_o     ),
    .wb_waddr_i    ( wb_waddr_o  ),
    .wb_wdata_i    ( wb_wdata_o  ),
    .rs1_o         ( rs1_id      ),
    .rs2_o         ( rs2_id      ),
    .rs1_re_o      ( rs1_re      ),
    .rs2_re_o      ( rs2_re      ),
    .ex_op_o       ( ex_op       ),
    .ex_opa_o      ( ex_opa      ),
    .ex_opb_o      ( ex_opb      ),
    .ex_imm_o      ( ex_imm      ),
    .ex_rd_o       ( ex_rd       ),
    .ex_we_o       ( ex_we       ),
    .ex_pc_o       ( ex_pc       ),
    .ex_valid_o    ( ex_valid    )
  );

  mcpu_ex_stage i_ex_stage (
    .clk             ( clk           ),
    .rst_i           ( rst_i         ),
    .ex_op_i         ( ex_op         ),
    .ex_opa_i        ( ex_opa        ),
    .ex_opb_i        ( ex_opb        ),
    .ex_imm_i        ( ex_imm        ),
    .ex_rd_i         ( ex_rd         ),
    .ex_we_i         ( ex_we         ),
    .ex_pc_i         ( ex_pc         ),
    .ex_valid_i      ( ex_valid      ),
    .ex_result_o     ( ex_result     ),
    .branch_taken_o  ( branch_taken  ),
    .branch_target_o ( branch_target ),
    .halt_ex_o       ( halt_ex       ),
    .rd_ex_o         ( rd_ex         ),
    .we_ex_o         ( we_ex         ),
    .load_ex_o       ( load_ex       ),
    .wb_we_o         ( wb_we_o       ),
    .wb_waddr_o      ( wb_waddr_o    ),
    .wb_wdata_o      ( wb_wdata_o    )
  );

  mcpu_controller i_controller (
    .clk            ( clk            ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .branch_taken_i ( branch_taken   ),
    .halt_ex_i      ( halt_ex        ),
    .rs1_id_i       ( rs1_id         ),
    .rs2_id_i       ( rs2_id         ),
    .rs1_re_i       ( rs1_re         ),
    .rs2_re_i       ( rs2_re         ),
    .if_valid_i     ( if_valid       ),
    .rd_ex_i        ( rd_ex          ),
    .we_ex_i        ( we_ex          ),
    .load_ex_i      ( load_ex        ),
    .rd_wb_i        ( wb_waddr_o     ),
    .we_wb_i        ( wb_we_o        ),
    .pc_set_o       ( pc_set         ),
    .halt_if_o      ( halt_if        ),
    .halt_id_o      ( halt_id        ),
    .kill_id_o      ( kill_id        ),
    .kill_ex_o      ( kill_ex        ),
    .fw_a_sel_o     ( fw_a_sel       ),
    .fw_b_sel_o     ( fw_b_sel       ),
    .deassert_we_o  ( deassert_we    ),
    .ctrl_busy_o    ( ctrl_busy_o    ),
    .halted_o       ( halted_o       )
  );

endmodule

`default_nettype wire

/* testbench/mcpu_checker.sv */
// Writeback and status checker of the mcpu testbench
// Compares each register write in order with the expected list
// and watches busy, halted and the write enable around the run
`timescale 1ns/1ns
`default_nettype none

module mcpu_checker import mcpu_pkg::*; #(
  parameter int EXP_MAX = 48
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        fetch_enable_i,
  input  logic        wb_we_i,
  input  rf_addr_t    wb_waddr_i,
  input  word_t       wb_wdata_i,
  input  logic        ctrl_busy_i,
  input  logic        halted_i,
  // Records as register digit plus 16-bit data
  input  logic [19:0] exp_rec_i [EXP_MAX],
  input  int          exp_count_i,
  input  logic        end_i,
  output logic        end_done_o,
  output int          data_errors_o,
  output int          status_errors_o,
  output int          missing_o
);

  int   rec_idx       = 0;
  int   data_errors   = 0;
  int   status_errors = 0;
  int   missing       = 0;
  logic halted_seen   = 1'b0;
  logic end_done      = 1'b0;

  assign data_errors_o   = data_errors;
  assign status_errors_o = status_errors;
  assign missing_o       = missing;
  assign end_done_o      = end_done;

  // Single-bit status compare
  task automatic expect_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h at %0t", name, exp, act, $time);
      status_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Write compare against the next record
  ////////////////////////////////////////////////////////////
  task automatic check_write();
    rf_addr_t exp_addr;
    word_t    exp_data;
    if (rec_idx >= exp_count_i) begin
      $display("Unexpected write to r%0d with %h after all %0d expected writes",
               wb_waddr_i, wb_wdata_i, exp_count_i);
      data_errors++;
    end else begin
      exp_addr = exp_rec_i[rec_idx][18:16];
      exp_data = exp_rec_i[rec_idx][15:0];
      if (wb_waddr_i !== exp_addr) begin
        $display("Error: wb_waddr_o expected %h actual %h (write %0d)",
                 exp_addr, wb_waddr_i, rec_idx);
        data_errors++;
      end
      if (wb_wdata_i !== exp_data) begin
        $display("Error: wb_wdata_o expected %h actual %h (write %0d)",
                 exp_data, wb_wdata_i, rec_idx);
        data_errors++;
      end
      // Retiring instructions only while running
      expect_level("ctrl_busy_o", 1'b1, ctrl_busy_i);
    end
    rec_idx++;
  endtask

  // Records that never showed up
  task automatic count_missing();
    if (rec_idx < exp_count_i) begin
      missing = exp_count_i - rec_idx;
      $display("Missing writes: only %0d of %0d expected writes appeared",
               rec_idx, exp_count_i);
    end
    end_done = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling mid-cycle, outputs settled
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!rst_i) begin
      // Parked after reset
      if (!fetch_enable_i) begin
        expect_level("ctrl_busy_o", 1'b0, ctrl_busy_i);
        expect_level("halted_o", 1'b0, halted_i);
        expect_level("wb_we_o", 1'b0, wb_we_i);
      end
      // HALTED is sticky until reset
      if (halted_seen) begin
        expect_level("halted_o", 1'b1, halted_i);
      end
      if (halted_i) begin
        expect_level("ctrl_busy_o", 1'b0, ctrl_busy_i);
        expect_level("wb_we_o", 1'b0, wb_we_i);
        halted_seen = 1'b1;
      end
      // r0 writes are dropped by the core
      if (wb_we_i && (wb_waddr_i != '0) && !halted_i) begin
        check_write();
      end
      if (end_i && !end_done) begin
        count_missing();
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_mcpu.sv */
// Testbench of the mcpu pipeline
// Loads program and expected writes from the trace file, serves
// the instruction port, starts the core and waits for HALT
`timescale 1ns/1ns
`default_nettype none

`include "mcpu_settings.svh"

module tb_mcpu import mcpu_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 10;
  // Idle cycles with fetch disabled
  localparam int IDLE_CYCLES  = 6;
  localparam int HALT_TIMEOUT = 2000;
  // Watch window after halt
  localparam int QUIET_CYCLES = 8;
  localparam int END_TIMEOUT  = 10;
  // Trace layout, word addresses in the data file
  localparam int TRACE_DEPTH  = 128;
  localparam int PROG_BASE    = 16;
  localparam int PROG_MAX     = 48;
  localparam int EXP_BASE     = 64;
  localparam int EXP_MAX      = 48;
  localparam int PROG_DEPTH   = 2 ** `MCPU_PC_W;
  localparam instr_t NOP_WORD = {NOP, 12'h000};

  logic        clk = 1'b0;
  logic        rst_i;
  logic        fetch_enable_i;
  pc_t         instr_addr;
  instr_t      instr_rdata;
  logic        wb_we;
  rf_addr_t    wb_waddr;
  word_t       wb_wdata;
  logic        ctrl_busy;
  logic        halted;

  logic [19:0] trace_mem [TRACE_DEPTH];
  instr_t      prog_mem  [PROG_DEPTH];
  logic [19:0] exp_rec   [EXP_MAX];
  int          prog_len;
  int          exp_count;
  logic        run_end;
  logic        end_checked;
  int          data_errors;
  int          status_errors;
  int          missing_writes;
  int          tb_errors;
  int          total_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Instruction ROM, combinational read, NOP past the program
  assign instr_rdata = prog_mem[instr_addr];

  mcpu_top i_mcpu_top (
    .clk            ( clk            ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_addr_o   ( instr_addr     ),
    .instr_rdata_i  ( instr_rdata    ),
    .wb_we_o        ( wb_we          ),
    .wb_waddr_o     ( wb_waddr       ),
    .wb_wdata_o     ( wb_wdata       ),
    .ctrl_busy_o    ( ctrl_busy      ),
    .halted_o       ( halted         )
  );

  mcpu_checker #(
    .EXP_MAX ( EXP_MAX )
  ) i_mcpu_checker (
    .clk             ( clk            ),
    .rst_i           ( rst_i          ),
    .fetch_enable_i  ( fetch_enable_i ),
    .wb_we_i         ( wb_we          ),
    .wb_waddr_i      ( wb_waddr       ),
    .wb_wdata_i      ( wb_wdata       ),
    .ctrl_busy_i     ( ctrl_busy      ),
    .halted_i        ( halted         ),
    .exp_rec_i       ( exp_rec        ),
    .exp_count_i     ( exp_count      ),
    .end_i           ( run_end        ),
    .end_done_o      ( end_checked    ),
    .data_errors_o   ( data_errors    ),
    .status_errors_o ( status_errors  ),
    .missing_o       ( missing_writes )
  );

  ////////////////////////////////////////////////////////////
  // Trace loading
  ////////////////////////////////////////////////////////////
  task automatic load_trace();
    $readmemh("testbench/mcpu_trace.txt", trace_mem);
    prog_len  = int'(trace_mem[0]);
    exp_count = int'(trace_mem[1]);
    if (prog_len > PROG_MAX || exp_count > EXP_MAX) begin
      $display("Trace header out of range: %0d program words, %0d writes",
               prog_len, exp_count);
      tb_errors++;
      prog_len  = 0;
      exp_count = 0;
    end
    for (int i = 0; i < PROG_DEPTH; i++) begin
      if (i < prog_len) begin
        prog_mem[i] = instr_t'(trace_mem[PROG_BASE + i]);
      end else begin
        prog_mem[i] = NOP_WORD;
      end
    end
    for (int j = 0; j < EXP_MAX; j++) begin
      if (j < exp_count) begin
        exp_rec[j] = trace_mem[EXP_BASE + j];
      end else begin
        exp_rec[j] = '0;
      end
    end
  endtask

  // Poll halted_o mid-cycle, bounded
  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (!halted) begin
      $display("Timeout: core did not halt within %0d cycles", HALT_TIMEOUT);
      tb_errors++;
    end
  endtask

  // Checker acknowledges the final count
  task automatic wait_for_end_check();
    int cycles;
    cycles = 0;
    while (!end_checked && cycles < END_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (!end_checked) begin
      $display("Timeout: checker did not finish its final count");
      tb_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    run_end        = 1'b0;
    tb_errors      = 0;
    load_trace();

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_i = 1'b0;

    // Core parked in BOOT, busy must stay low
    repeat (IDLE_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    fetch_enable_i = 1'b1;

    wait_for_halt();
    // No writes may follow HALT
    if (halted) begin
      repeat (QUIET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
    end
    run_end = 1'b1;
    wait_for_end_check();

    total_errors = data_errors + status_errors + missing_writes + tb_errors;
    $display("Errors: %0d total, %0d write, %0d status, %0d missing, %0d testbench",
             total_errors, data_errors, status_errors, missing_writes, tb_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/mcpu_trace.txt */
// mcpu trace: @00 program length, @01 expected write count (hex)
// @10 program words, @40 expected writes as register digit then 4-digit data
@00
17      // 23 program words
0d      // 13 expected writes
@10
4205    // 00 ADDI r1, r0, 5
443d    // 01 ADDI r2, r0, -3
0650    // 02 ADD  r3, r1, r2    r1 from WB, r2 from EX
18c8    // 03 SUB  r4, r3, r1    r3 from EX
2b08    // 04 AND  r5, r4, r1
3d50    // 05 OR   r6, r5, r2
4047    // 06 ADDI r0, r1, 7     dropped
0e08    // 07 ADD  r7, r0, r1    r0 reads zero
6643    // 08 ST   r3, 3(r1)     mem[8] = 2
5443    // 09 LD   r2, 3(r1)
0688    // 0a ADD  r3, r2, r1    load-use stall
77c2    // 0b BEQ  r3, r7, +2    not taken
4901    // 0c ADDI r4, r4, 1
7bc2    // 0d BEQ  r5, r7, +2    taken to 0x10
421f    // 0e ADDI r1, r0, 31    squashed
441e    // 0f ADDI r2, r0, 30    squashed
0d28    // 10 ADD  r6, r4, r5
6c00    // 11 ST   r6, 0(r0)     mem[0] = 3
5e00    // 12 LD   r7, 0(r0)
1a78    // 13 SUB  r5, r1, r7    load-use on second source
8000    // 14 HALT
4209    // 15 ADDI r1, r0, 9     never retires
440a    // 16 ADDI r2, r0, 10    never retires
@40
10005   // r1
2fffd   // r2
30002   // r3
4fffd   // r4
50005   // r5
6fffd   // r6
70005   // r7
20002   // r2 loaded
30007   // r3 after stall
4fffe   // r4
60003   // r6
70003   // r7 loaded
50002   // r5

/* sources.f */
+incdir+common
common/mcpu_pkg.sv
hw/controller/mcpu_controller_fsm.sv
hw/controller/mcpu_controller_bypass.sv
hw/controller/mcpu_controller.sv
hw/mcpu_if_stage.sv
hw/mcpu_id_stage.sv
hw/mcpu_ex_stage.sv
hw/mcpu_top.sv
testbench/mcpu_checker.sv
testbench/tb_mcpu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the mcpu testbench with Verilator
# Pass or fail comes from a search of the simulation log
mkdir -p build &&
rm -f build/sim.log &&
verilator --binary --timing --timescale 1ns/1ns --top-module tb_mcpu \
  -Mdir build/obj_dir -o tb_mcpu -f sources.f &&
build/obj_dir/tb_mcpu | tee build/sim.log &&
grep -q "Simulation finished: PASS" build/sim.log &&
echo "run_sim: test passed" ||
{ echo "run_sim: test failed"; exit 1; }
